//--- uart_pkg.sv
package uart_pkg;

    // widths --------------------------------------------
    localparam int bus_width      = 32; // host data bus
    localparam int addr_width     = 4;  // byte address inside peripheral
    localparam int byte_width     = 8;  // one character
    localparam int baud_width     = 10; // baud divisor field
    localparam int prsc_width     = 3;  // prescaler select field
    localparam int bitcnt_width   = 4;  // frame bit counter
    localparam int prsc_cnt_width = 12; // prescaler counter, covers clk/4096

    typedef logic [bus_width-1:0]    bus_data_t;
    typedef logic [addr_width-1:0]   bus_addr_t;
    typedef logic [byte_width-1:0]   byte_t;
    typedef logic [baud_width-1:0]   baud_div_t; // bit lasts baud+1 ticks
    typedef logic [prsc_width-1:0]   prsc_sel_t;
    typedef logic [bitcnt_width-1:0] bit_cnt_t;

    // register map --------------------------------------
    localparam bus_addr_t ctrl_addr   = 4'h0;
    localparam bus_addr_t data_addr   = 4'h4;
    localparam int        reg_sel_bit = 2;  // only addr bit that decodes

    localparam int en_bit        = 0;  // r/w uart enable
    localparam int prsc_lsb      = 3;  // r/w prescaler select, 3 bits
    localparam int baud_lsb      = 6;  // r/w baud divisor, 10 bits
    localparam int rx_nempty_bit = 16; // r/- rx fifo not empty
    localparam int rx_half_bit   = 17; // r/- rx fifo at least half full
    localparam int rx_full_bit   = 18; // r/- rx fifo full
    localparam int tx_empty_bit  = 19; // r/- tx fifo empty
    localparam int tx_nhalf_bit  = 20; // r/- tx fifo below half
    localparam int tx_full_bit   = 21; // r/- tx fifo full
    localparam int rx_over_bit   = 30; // r/- rx overrun
    localparam int tx_busy_bit   = 31; // r/- transmitter busy or data pending

    // frame and buffers
    localparam int tx_frame_bits      = 11; // start + 8 data + stop + pause
    localparam int rx_frame_bits      = 10; // start + 8 data + stop
    localparam int fifo_depth_default = 4;

    typedef struct packed {
        logic      enable;
        prsc_sel_t prsc;
        baud_div_t baud;
    } uart_cfg_t; // 14 bits

    typedef struct packed {
        logic avail; // at least one entry
        logic half;  // at least half full
        logic free;  // at least one slot left
    } fifo_stat_t;

    typedef enum logic [1:0] {tx_off, tx_idle, tx_load, tx_send} tx_state_e;
    typedef enum logic [1:0] {rx_off, rx_idle, rx_recv} rx_state_e;

endpackage

//--- uart_fifo.sv
`timescale 1ns/1ns

module uart_fifo import uart_pkg::*; #(
    parameter int depth = fifo_depth_default // entries, power of two, min 1
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       clear_i,  // sync clear, high active
    input  logic       we_i,     // push
    input  byte_t      wdata_i,
    input  logic       re_i,     // pop, data valid next cycle
    output byte_t      rdata_o,  // registered read data
    output fifo_stat_t stat_o
);
    localparam int pw = $clog2(depth) + 1;                  // pointer incl. wrap bit
    localparam int iw = (depth > 1) ? $clog2(depth) : 1;    // storage index width
    localparam logic [pw-1:0] idx_mask = pw'(depth - 1);    // strips wrap bit
    localparam logic [pw-1:0] half_lvl = pw'((depth + 1) / 2);

    byte_t         mem [depth];   // storage
    logic [pw-1:0] w_ptr;         // write pointer
    logic [pw-1:0] r_ptr;         // read pointer
    logic [pw-1:0] level;         // fill level
    logic [iw-1:0] w_idx;
    logic [iw-1:0] r_idx;
    logic          full;
    logic          empty;
    logic          do_we;         // accepted write
    logic          do_re;         // accepted read

    assign level = w_ptr - r_ptr;              // wrap bit makes full/empty distinct
    assign full  = (level == pw'(depth));
    assign empty = (level == '0);
    assign w_idx = iw'(w_ptr & idx_mask);
    assign r_idx = iw'(r_ptr & idx_mask);
    assign do_we = we_i & ~full;               // overflow ignored
    assign do_re = re_i & ~empty;              // underflow ignored

    // pointers ------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            w_ptr <= '0;
            r_ptr <= '0;
        end else if (clear_i) begin            // clear drops all entries
            w_ptr <= '0;
            r_ptr <= '0;
        end else begin
            if (do_we) w_ptr <= w_ptr + 1'b1;
            if (do_re) r_ptr <= r_ptr + 1'b1;
        end
    end

    // storage and sync read
    always_ff @(posedge clk_i) begin
        if (do_we && !clear_i) mem[w_idx] <= wdata_i;
        if (do_re) rdata_o <= mem[r_idx];      // holds until next pop
    end

    assign stat_o.avail = ~empty;
    assign stat_o.half  = (level >= half_lvl);
    assign stat_o.free  = ~full;

endmodule

//--- uart_regs.sv
`timescale 1ns/1ns

module uart_regs import uart_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    // host bus
    input  bus_addr_t  addr_i,
    input  logic       wren_i,
    input  logic       rden_i,
    input  bus_data_t  data_i,
    output bus_data_t  data_o,     // zero while ack_o low
    output logic       ack_o,
    // configuration
    output uart_cfg_t  cfg_o,
    // tx fifo write side
    output logic       tx_we_o,
    output byte_t      tx_wdata_o,
    // rx fifo read side
    output logic       rx_re_o,
    input  byte_t      rx_rdata_i,
    // status sources
    input  fifo_stat_t tx_stat_i,
    input  fifo_stat_t rx_stat_i,
    input  logic       tx_busy_i,
    input  logic       rx_done_i   // rx fifo write strobe
);
    logic      sel_ctrl;   // control register addressed
    logic      sel_data;   // data register addressed
    logic      rden_q;     // read delayed for sync fifo read
    logic      rd_data_q;  // delayed read targets data register
    logic      rx_over;    // rx overrun flag
    bus_data_t ctrl_word;  // control/status read value

    assign sel_ctrl = (addr_i[reg_sel_bit] == ctrl_addr[reg_sel_bit]);
    assign sel_data = (addr_i[reg_sel_bit] == data_addr[reg_sel_bit]);

    assign tx_we_o    = wren_i & sel_data;           // push char to tx fifo
    assign tx_wdata_o = data_i[byte_width-1:0];
    assign rx_re_o    = rden_i & sel_data;           // pop char, lands next cycle

    // control register ----------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_o <= '0;
        end else if (wren_i && sel_ctrl) begin
            cfg_o.enable <= data_i[en_bit];
            cfg_o.prsc   <= data_i[prsc_lsb +: prsc_width];
            cfg_o.baud   <= data_i[baud_lsb +: baud_width];
        end
    end

    // status word, unused bits stay zero
    always_comb begin
        ctrl_word                              = '0;
        ctrl_word[en_bit]                      = cfg_o.enable;
        ctrl_word[prsc_lsb +: prsc_width]      = cfg_o.prsc;
        ctrl_word[baud_lsb +: baud_width]      = cfg_o.baud;
        ctrl_word[rx_nempty_bit]               = rx_stat_i.avail;
        ctrl_word[rx_half_bit]                 = rx_stat_i.half;
        ctrl_word[rx_full_bit]                 = ~rx_stat_i.free;
        ctrl_word[tx_empty_bit]                = ~tx_stat_i.avail;
        ctrl_word[tx_nhalf_bit]                = ~tx_stat_i.half;
        ctrl_word[tx_full_bit]                 = ~tx_stat_i.free;
        ctrl_word[rx_over_bit]                 = rx_over;
        ctrl_word[tx_busy_bit]                 = tx_busy_i | tx_stat_i.avail; // engine or queue
    end

    // read path and acknowledge -------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rden_q    <= 1'b0;
            rd_data_q <= 1'b0;
            ack_o     <= 1'b0;
            data_o    <= '0;
        end else begin
            rden_q    <= rden_i;                     // wait for fifo read data
            rd_data_q <= sel_data;
            ack_o     <= wren_i | rden_q;            // write +1, read +2
            data_o    <= '0;
            if (rden_q) begin
                if (rd_data_q) data_o <= bus_data_t'(rx_rdata_i);
                else           data_o <= ctrl_word;
            end
        end
    end

    // overrun: char received while rx fifo full
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rx_over <= 1'b0;
        end else if (rx_re_o || !cfg_o.enable) begin // data read or disable clears
            rx_over <= 1'b0;
        end else if (rx_done_i && !rx_stat_i.free) begin
            rx_over <= 1'b1;
        end
    end

endmodule

//--- uart_prescaler.sv
`timescale 1ns/1ns

module uart_prescaler import uart_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  uart_cfg_t cfg_i,
    output logic      tick_o   // one cycle per prescaler period
);
    logic [prsc_cnt_width-1:0] cnt;   // free running while enabled
    logic                      tap;   // selected counter bit
    logic                      tap_q; // tap of last cycle

    // tap bit k rises every 2^(k+1) clocks
    always_comb begin
        case (cfg_i.prsc)
            3'd0:    tap = cnt[0];   // clk/2
            3'd1:    tap = cnt[1];   // clk/4
            3'd2:    tap = cnt[2];   // clk/8
            3'd3:    tap = cnt[5];   // clk/64
            3'd4:    tap = cnt[6];   // clk/128
            3'd5:    tap = cnt[9];   // clk/1024
            3'd6:    tap = cnt[10];  // clk/2048
            default: tap = cnt[11];  // clk/4096
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt   <= '0;
            tap_q <= 1'b0;
        end else if (!cfg_i.enable) begin // held while disabled
            cnt   <= '0;
            tap_q <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;
            tap_q <= tap;
        end
    end

    assign tick_o = tap & ~tap_q;         // rising edge of tap
endmodule

//--- uart_tx.sv
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  uart_cfg_t  cfg_i,
    input  logic       tick_i,   // baud tick from prescaler
    input  fifo_stat_t stat_i,   // tx fifo flags
    input  byte_t      rdata_i,  // tx fifo read data
    output logic       re_o,     // tx fifo pop
    output logic       busy_o,
    output logic       txd_o     // serial line, idle high
);
    tx_state_e           state;
    logic [byte_width:0] sreg;     // data and start bit, lsb on line
    bit_cnt_t            bitcnt;   // bits left in frame
    baud_div_t           baudcnt;  // ticks left in current bit
    logic                bit_end;  // last tick of a bit

    assign bit_end = (state == tx_send) && tick_i && (baudcnt == '0) && (bitcnt != '0);

    // frame FSM -----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= tx_off;
            bitcnt  <= '0;
            baudcnt <= '0;
        end else if (!cfg_i.enable) begin
            state   <= tx_off;                     // disable aborts any frame
        end else begin
            unique case (state)
                tx_off: begin
                    state <= tx_idle;
                end
                tx_idle: begin                     // wait for a char
                    baudcnt <= cfg_i.baud;
                    bitcnt  <= bit_cnt_t'(tx_frame_bits);
                    if (stat_i.avail) state <= tx_load;
                end
                tx_load: begin                     // fifo data valid now
                    state <= tx_send;
                end
                tx_send: begin
                    if (bitcnt == '0) begin        // pause bit done
                        state <= tx_idle;
                    end else if (tick_i) begin
                        if (baudcnt == '0) begin
                            baudcnt <= cfg_i.baud;
                            bitcnt  <= bitcnt - 1'b1;
                        end else begin
                            baudcnt <= baudcnt - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= tx_off;
                end
            endcase
        end
    end

    // shift register
    always_ff @(posedge clk_i) begin
        if (state == tx_load) begin
            sreg <= {rdata_i, 1'b0};               // char behind start bit
        end else if (bit_end) begin
            sreg <= {1'b1, sreg[byte_width:1]};    // ones give stop and pause
        end
    end

    assign re_o   = (state == tx_idle) & stat_i.avail;
    assign busy_o = (state == tx_load) | (state == tx_send);
    assign txd_o  = (state == tx_send) ? sreg[0] : 1'b1; // lsb first

endmodule

//--- uart_rx.sv
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  uart_cfg_t cfg_i,
    input  logic      tick_i,   // baud tick from prescaler
    input  logic      rxd_i,    // async serial line
    output logic      done_o,   // one cycle, char valid
    output byte_t     data_o
);
    logic [2:0]               sync;     // [2] clk domain, [1:0] tick domain
    rx_state_e                state;
    logic [rx_frame_bits-1:0] sreg;     // stop, data, start after full frame
    bit_cnt_t                 bitcnt;   // samples left
    baud_div_t                baudcnt;  // ticks to next sample
    logic                     bit_end;  // sample point

    assign bit_end = (state == rx_recv) && tick_i && (baudcnt == '0) && (bitcnt != '0);

    // input synchroniser
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sync <= '1;                                // line idles high
        end else begin
            sync[2] <= rxd_i;
            if (tick_i) sync[1:0] <= sync[2:1];
        end
    end

    // receive FSM ---------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state   <= rx_off;
            bitcnt  <= '0;
            baudcnt <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!cfg_i.enable) begin
                state <= rx_off;
            end else begin
                unique case (state)
                    rx_off: begin
                        state <= rx_idle;
                    end
                    rx_idle: begin
                        baudcnt <= cfg_i.baud >> 1;    // half bit, hit bit centre
                        bitcnt  <= bit_cnt_t'(rx_frame_bits);
                        if (sync[1:0] == 2'b01) state <= rx_recv; // falling edge
                    end
                    rx_recv: begin
                        if (bitcnt == '0) begin        // stop bit sampled
                            done_o <= 1'b1;
                            state  <= rx_idle;
                        end else if (tick_i) begin
                            if (baudcnt == '0) begin
                                baudcnt <= cfg_i.baud;
                                bitcnt  <= bitcnt - 1'b1;
                            end else begin
                                baudcnt <= baudcnt - 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= rx_off;
                    end
                endcase
            end
        end
    end

    // sample shift, lsb arrives first
    always_ff @(posedge clk_i) begin
        if (bit_end) sreg <= {sync[2], sreg[rx_frame_bits-1:1]};
    end

    assign data_o = sreg[byte_width:1];                // drop start and stop

endmodule

//--- uart_top.sv
`timescale 1ns/1ns

module uart_top import uart_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  bus_addr_t addr_i,
    input  logic      wren_i,
    input  logic      rden_i,
    input  bus_data_t data_i,
    output bus_data_t data_o,
    output logic      ack_o,
    output logic      uart_txd_o,
    input  logic      uart_rxd_i
);
    uart_cfg_t  cfg;       // control register fields
    logic       tick;      // baud tick
    logic       tx_we;     // host -> tx fifo
    byte_t      tx_wdata;
    logic       tx_re;     // tx fifo -> engine
    byte_t      tx_rdata;
    fifo_stat_t tx_stat;
    logic       tx_busy;
    logic       rx_done;   // engine -> rx fifo
    byte_t      rx_byte;
    logic       rx_re;     // rx fifo -> host
    byte_t      rx_rdata;
    fifo_stat_t rx_stat;

    // host side -----------------------------------------
    uart_regs u_regs (
        .clk_i, .rstn_i,
        .addr_i, .wren_i, .rden_i, .data_i, .data_o, .ack_o,
        .cfg_o      (cfg),
        .tx_we_o    (tx_we),
        .tx_wdata_o (tx_wdata),
        .rx_re_o    (rx_re),
        .rx_rdata_i (rx_rdata),
        .tx_stat_i  (tx_stat),
        .rx_stat_i  (rx_stat),
        .tx_busy_i  (tx_busy),
        .rx_done_i  (rx_done)
    );

    uart_prescaler u_prescaler (.clk_i, .rstn_i, .cfg_i(cfg), .tick_o(tick));

    // transmit path -------------------------------------
    uart_fifo #(.depth(fifo_depth_default)) u_tx_fifo (
        .clk_i, .rstn_i,
        .clear_i (~cfg.enable),    // flushed while disabled
        .we_i    (tx_we),
        .wdata_i (tx_wdata),
        .re_i    (tx_re),
        .rdata_o (tx_rdata),
        .stat_o  (tx_stat)
    );

    uart_tx u_tx (
        .clk_i, .rstn_i, .cfg_i(cfg), .tick_i(tick),
        .stat_i(tx_stat), .rdata_i(tx_rdata),
        .re_o(tx_re), .busy_o(tx_busy), .txd_o(uart_txd_o)
    );

    // receive path --------------------------------------
    uart_rx u_rx (
        .clk_i, .rstn_i, .cfg_i(cfg), .tick_i(tick),
        .rxd_i(uart_rxd_i), .done_o(rx_done), .data_o(rx_byte)
    );

    uart_fifo #(.depth(fifo_depth_default)) u_rx_fifo (
        .clk_i, .rstn_i,
        .clear_i (~cfg.enable),
        .we_i    (rx_done),        // full fifo drops char
        .wdata_i (rx_byte),
        .re_i    (rx_re),
        .rdata_o (rx_rdata),
        .stat_o  (rx_stat)
    );

endmodule

//--- uart_checker.sv
`timescale 1ns/1ns

module uart_checker import uart_pkg::*; (
    input logic      clk_i,
    input logic      rstn_i,
    input uart_cfg_t cfg_i,    // control register fields
    input logic      wren_i,   // host write strobe
    input logic      ack_i,
    input bus_data_t data_i,   // host read data
    input logic      txd_i     // serial output
);

    // serial line ---------------------------------------
    // tx engine sees a disable one cycle after the register
    a_txd_idle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (!cfg_i.enable && !$past(cfg_i.enable)) |-> txd_i
    ) else $error("uart_txd_o low while the uart is disabled");

    // host bus ------------------------------------------
    a_data_zero: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !ack_i |-> (data_i == '0)
    ) else $error("data_o not zero without ack_o");

    a_write_ack: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wren_i |=> ack_i                          // write acked next cycle
    ) else $error("ack_o missing one cycle after a write");

endmodule

bind uart_top uart_checker u_checker (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .cfg_i  (cfg),
    .wren_i (wren_i),
    .ack_i  (ack_o),
    .data_i (data_o),
    .txd_i  (uart_txd_o)
);

//--- tb_uart.sv
`timescale 1ns/1ns

module tb_uart import uart_pkg::*; ();

    typedef enum logic [2:0] {
        op_wr, op_rd, op_poll, op_rd_byte, op_txd, op_mode, op_frame
    } op_e;

    typedef struct packed {
        op_e       op;
        bus_addr_t addr;
        bus_data_t wval;   // write value, poll mask or frame byte
        bus_data_t exp;    // expected word, byte or line level
    } step_t;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    bus_addr_t addr_i;
    logic      wren_i;
    logic      rden_i;
    bus_data_t data_i;
    bus_data_t data_o;
    logic      ack_o;
    logic      uart_txd_o;
    logic      uart_rxd_i;
    logic      loopback = 1'b0;  // 1 feeds txd back into rxd
    logic      rxd_drv  = 1'b1;  // direct mode line level
    step_t     steps[$];         // stimulus table
    int        seed = 32'h8726_fb71;
    prsc_sel_t cur_prsc = '0;    // last written prescaler select
    baud_div_t cur_baud = '0;    // last written divisor
    int        div_tab[8] = '{2, 4, 8, 64, 128, 1024, 2048, 4096}; // clocks per tick

    always #5 clk_i = ~clk_i;
    assign uart_rxd_i = loopback ? uart_txd_o : rxd_drv;

    uart_top u_uart_top (
        .clk_i, .rstn_i, .addr_i, .wren_i, .rden_i, .data_i, .data_o, .ack_o,
        .uart_txd_o, .uart_rxd_i
    );

    // reporting -----------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    endtask

    // bus access ----------------------------------------
    task automatic bus_write(input bus_addr_t addr, input bus_data_t wval);
        int n;
        @(posedge clk_i);
        #1;
        addr_i = addr;
        data_i = wval;
        wren_i = 1'b1;
        @(posedge clk_i);
        #1;
        wren_i = 1'b0;                            // ack due now
        for (n = 0; n < 8 && !ack_o; n++) begin
            @(posedge clk_i);
            #1;
        end
        if (!ack_o) abort_run("bus write was never acknowledged");
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t rval);
        int n;
        @(posedge clk_i);
        #1;
        addr_i = addr;
        rden_i = 1'b1;
        @(posedge clk_i);
        #1;
        rden_i = 1'b0;
        for (n = 0; n < 8 && !ack_o; n++) begin   // data follows one cycle later
            @(posedge clk_i);
            #1;
        end
        rval = data_o;
        if (!ack_o) abort_run("bus read was never acknowledged");
    endtask

    // re-read status until the masked bits match
    task automatic poll_status(input bus_data_t mask, input bus_data_t value);
        bus_data_t w;
        int        n;
        bus_read(ctrl_addr, w);
        for (n = 0; n < 4000 && (w & mask) != value; n++)
            bus_read(ctrl_addr, w);
        if ((w & mask) != value)
            abort_run($sformatf("timeout waiting for status %h under mask %h", value, mask));
    endtask

    // start, data lsb first, stop, then one idle bit
    task automatic drive_frame(input byte_t b);
        logic [rx_frame_bits-1:0] frame;
        int                       clks;
        int                       i;
        frame = {1'b1, b, 1'b0};
        clks  = (int'(cur_baud) + 1) * div_tab[cur_prsc];
        @(posedge clk_i);
        #1;
        for (i = 0; i < rx_frame_bits; i++) begin
            rxd_drv = frame[i];
            repeat (clks) @(posedge clk_i);
            #1;
        end
        rxd_drv = 1'b1;
        repeat (clks) @(posedge clk_i);
    endtask

    // expected values -----------------------------------
    function automatic bus_data_t flag(input int pos);
        return bus_data_t'(1) << pos;
    endfunction

    function automatic bus_data_t ctrl_fields(input logic en, input prsc_sel_t p, input baud_div_t b);
        bus_data_t w;
        w = '0;
        w[en_bit] = en;
        w[prsc_lsb +: prsc_width] = p;
        w[baud_lsb +: baud_width] = b;
        return w;
    endfunction

    task automatic add_step(input op_e op, input bus_addr_t addr, input bus_data_t wval,
                            input bus_data_t exp);
        steps.push_back(step_t'{op, addr, wval, exp});
    endtask

    task automatic build_table();
        bus_data_t idle_st;
        bus_data_t rx_st;
        bus_data_t f;
        byte_t     b;
        byte_t     lb_bytes[4] = '{8'ha5, 8'h3c, 8'h00, 8'hff};
        byte_t     sent[fifo_depth_default+1];
        int        i;
        idle_st = flag(tx_empty_bit) | flag(tx_nhalf_bit);   // both fifos empty
        rx_st   = flag(rx_nempty_bit) | flag(rx_half_bit);
        add_step(op_txd, ctrl_addr, '0, 32'd1);
        add_step(op_rd, ctrl_addr, '0, idle_st);
        // fields read back, bits 1, 2 and 22..26 stay zero
        f = ctrl_fields(1'b1, 3'd5, 10'h2a5);
        add_step(op_wr, ctrl_addr, f | 32'h07c0_0006, '0);
        add_step(op_rd, ctrl_addr, '0, f | idle_st);
        f = ctrl_fields(1'b0, 3'd7, 10'h3ff);
        add_step(op_wr, ctrl_addr, f | 32'h07c0_0006, '0);
        add_step(op_rd, ctrl_addr, '0, f | idle_st);
        // direct line, clk/4 ticks, 6 ticks a bit
        f = ctrl_fields(1'b1, 3'd1, 10'd5);
        add_step(op_wr, ctrl_addr, f, '0);
        for (i = 0; i < 2; i++) begin
            b = byte_t'($random(seed));
            add_step(op_frame, data_addr, bus_data_t'(b), '0);
            add_step(op_poll, ctrl_addr, flag(rx_nempty_bit), flag(rx_nempty_bit));
            add_step(op_rd_byte, data_addr, '0, bus_data_t'(b));
        end
        // loopback -------------------------------------
        add_step(op_mode, ctrl_addr, 32'd1, '0);
        f = ctrl_fields(1'b1, 3'd0, 10'd3);
        add_step(op_wr, ctrl_addr, f, '0);
        for (i = 0; i < 4; i++)
            add_step(op_wr, data_addr, bus_data_t'(lb_bytes[i]), '0);
        for (i = 0; i < 4; i++) begin
            add_step(op_poll, ctrl_addr, flag(rx_nempty_bit), flag(rx_nempty_bit));
            add_step(op_rd_byte, data_addr, '0, bus_data_t'(lb_bytes[i]));
        end
        add_step(op_poll, ctrl_addr, flag(tx_busy_bit), '0);
        add_step(op_rd, ctrl_addr, '0, f | idle_st);
        // fill the rx fifo, then overrun it
        for (i = 0; i <= fifo_depth_default; i++)
            sent[i] = byte_t'($random(seed));
        for (i = 0; i < fifo_depth_default; i++)
            add_step(op_wr, data_addr, bus_data_t'(sent[i]), '0);
        add_step(op_poll, ctrl_addr, flag(rx_full_bit), flag(rx_full_bit));
        add_step(op_poll, ctrl_addr, flag(tx_busy_bit), '0);
        add_step(op_rd, ctrl_addr, '0, f | rx_st | flag(rx_full_bit) | idle_st);
        add_step(op_wr, data_addr, bus_data_t'(sent[fifo_depth_default]), '0);
        add_step(op_poll, ctrl_addr, flag(rx_over_bit), flag(rx_over_bit));
        add_step(op_poll, ctrl_addr, flag(tx_busy_bit), '0);
        add_step(op_rd, ctrl_addr, '0,
                 f | rx_st | flag(rx_full_bit) | flag(rx_over_bit) | idle_st);
        add_step(op_rd_byte, data_addr, '0, bus_data_t'(sent[0]));
        add_step(op_rd, ctrl_addr, '0, f | rx_st | idle_st);   // one entry freed
        // overrun once more and leave bytes queued for the tx engine
        for (i = 0; i < 2; i++)
            add_step(op_wr, data_addr, bus_data_t'(byte_t'($random(seed))), '0);
        add_step(op_poll, ctrl_addr, flag(rx_over_bit), flag(rx_over_bit));
        for (i = 0; i < 2; i++)
            add_step(op_wr, data_addr, bus_data_t'(byte_t'($random(seed))), '0);
        add_step(op_poll, ctrl_addr, flag(tx_empty_bit), '0);  // tx data pending
        // disable flushes both fifos
        f = ctrl_fields(1'b0, 3'd0, 10'd3);
        add_step(op_wr, ctrl_addr, f, '0);
        add_step(op_rd, ctrl_addr, '0, f | idle_st);
        add_step(op_txd, ctrl_addr, '0, 32'd1);
    endtask

    // main sequence -------------------------------------
    initial begin
        step_t     s;
        bus_data_t rval;
        rstn_i = 1'b0;
        addr_i = '0;
        wren_i = 1'b0;
        rden_i = 1'b0;
        data_i = '0;
        build_table();
        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        foreach (steps[k]) begin
            s = steps[k];
            case (s.op)
                op_wr: begin
                    bus_write(s.addr, s.wval);
                    if (s.addr == ctrl_addr) begin         // track bit time for direct mode
                        cur_prsc = s.wval[prsc_lsb +: prsc_width];
                        cur_baud = s.wval[baud_lsb +: baud_width];
                    end
                end
                op_rd: begin
                    bus_read(s.addr, rval);
                    check_word("data_o", rval, s.exp);
                end
                op_rd_byte: begin
                    bus_read(s.addr, rval);
                    check_byte("data_o[7:0]", rval[byte_width-1:0], s.exp[byte_width-1:0]);
                end
                op_poll:  poll_status(s.wval, s.exp);
                op_txd:   check_bit("uart_txd_o", uart_txd_o, s.exp[0]);
                op_mode:  loopback = s.wval[0];
                op_frame: drive_frame(s.wval[byte_width-1:0]);
                default:  abort_run("unknown operation in stimulus table");
            endcase
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- src.f
uart_pkg.sv
uart_fifo.sv
uart_regs.sv
uart_prescaler.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_checker.sv
tb_uart.sv

//--- Makefile
TOP = tb_uart

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
